/* cpu_defines.svh */
////////////////////////////////////////////////////////////
// CPU build constants
////////////////////////////////////////////////////////////

`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Data and address width in bits
`define WORD_W 16

// General register count, no hard-wired zero
`define REG_CNT 8

// First fetch address after reset
`define RESET_PC 0

`endif

/* cpuPkg.sv */
////////////////////////////////////////////////////////////
// CPU types and pipeline payloads
////////////////////////////////////////////////////////////

`default_nettype none

`include "cpu_defines.svh"

package cpuPkg;

    typedef logic [`WORD_W-1:0] wordT;
    typedef logic [$clog2(`REG_CNT)-1:0] regIdxT;

    // Codes 4'hB to 4'hF are illegal
    typedef enum logic [3:0] {
        opNop  = 4'h0,
        opAdd  = 4'h1,
        opSub  = 4'h2,
        opAnd  = 4'h3,
        opXor  = 4'h4,
        opAddi = 4'h5,
        opLd   = 4'h6,
        opSt   = 4'h7,
        opBeqz = 4'h8,
        opBnez = 4'h9,
        opHalt = 4'hA
    } opcodeT;

    typedef struct packed {
        logic   valid;
        wordT   pcPlus1;
        wordT   instr;
    } ifIdT;

    // rtVal carries rd's value for a store
    typedef struct packed {
        logic   valid;
        opcodeT op;
        regIdxT rd;
        regIdxT rs;
        regIdxT rt;
        wordT   rsVal;
        wordT   rtVal;
        wordT   imm;
        wordT   pcPlus1;
        logic   regWrite;
        logic   memRead;
        logic   memWrite;
        logic   halt;
    } idExT;

    typedef struct packed {
        logic   valid;
        wordT   result;
        wordT   storeData;
        regIdxT rd;
        logic   regWrite;
        logic   memRead;
        logic   memWrite;
        logic   halt;
    } exMemT;

    typedef struct packed {
        logic   valid;
        wordT   data;
        regIdxT rd;
        logic   regWrite;
        logic   halt;
    } memWbT;

endpackage

`default_nettype wire

/* pipeReg.sv */
////////////////////////////////////////////////////////////
// Pipeline stage register
////////////////////////////////////////////////////////////

`default_nettype none

module pipeReg #(
    parameter type payloadT = logic
) (
    input  wire     clk,
    input  wire     rstN,
    input  wire     stall,
    input  wire     flush,
    input  payloadT d,
    output payloadT q
);

    // Bubble is all zeros, so valid drops with it
    always_ff @(posedge clk) begin
        if (!rstN) begin
            q <= '0;
        end else if (stall) begin
            q <= q;
        end else if (flush) begin
            q <= '0;
        end else begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

/* fetchStage.sv */
////////////////////////////////////////////////////////////
// Instruction fetch
////////////////////////////////////////////////////////////

`default_nettype none

`include "cpu_defines.svh"

module fetchStage (
    input  wire                clk,
    input  wire                rstN,
    input  wire                stall,
    input  wire                redirect,
    input  wire  [`WORD_W-1:0] target,
    input  wire                halted,
    input  wire  [`WORD_W-1:0] instrData,
    output logic [`WORD_W-1:0] instrAddr,
    output cpuPkg::ifIdT       ifIdNext
);

    logic [`WORD_W-1:0] pc;
    logic [`WORD_W-1:0] pcPlus1;

    assign pcPlus1   = pc + `WORD_W'(1);
    assign instrAddr = pc;

    // Hold has priority so a stalled branch redirects once it moves on
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= `WORD_W'(`RESET_PC);
        end else if (stall || halted) begin
            pc <= pc;
        end else if (redirect) begin
            pc <= target;
        end else begin
            pc <= pcPlus1;
        end
    end

    // Instruction ROM answers in the same cycle
    assign ifIdNext.valid   = !halted;
    assign ifIdNext.pcPlus1 = pcPlus1;
    assign ifIdNext.instr   = instrData;

endmodule

`default_nettype wire

/* decodeStage.sv */
////////////////////////////////////////////////////////////
// Decode and register file
////////////////////////////////////////////////////////////

`default_nettype none

`include "cpu_defines.svh"

module decodeStage (
    input  wire             clk,
    input  wire             rstN,
    input  cpuPkg::ifIdT    ifId,
    input  cpuPkg::memWbT   memWb,
    output cpuPkg::idExT    idExNext,
    output cpuPkg::regIdxT  rs,
    output cpuPkg::regIdxT  rt,
    output logic            usesRt
);

    cpuPkg::opcodeT op;
    cpuPkg::regIdxT rdF;
    cpuPkg::regIdxT rtF;
    cpuPkg::wordT   imm;
    cpuPkg::wordT   regs [`REG_CNT];
    cpuPkg::wordT   rsVal;
    cpuPkg::wordT   rtVal;
    logic           wbWrite;
    logic           isRType;
    logic           regWrite;
    logic           memRead;
    logic           memWrite;
    logic           halt;

    // Field split
    assign op  = cpuPkg::opcodeT'(ifId.instr[15:12]);
    assign rdF = ifId.instr[11:9];
    assign rs  = ifId.instr[8:6];
    assign rtF = ifId.instr[5:3];
    assign imm = {{(`WORD_W-6){ifId.instr[5]}}, ifId.instr[5:0]};

    // Store data comes from rd, read through the second port
    assign rt     = (op == cpuPkg::opSt) ? rdF : rtF;
    assign usesRt = isRType || (op == cpuPkg::opSt);

    always_comb begin
        isRType  = 1'b0;
        regWrite = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        halt     = 1'b0;
        case (op)
            cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opAnd, cpuPkg::opXor: begin
                isRType  = 1'b1;
                regWrite = 1'b1;
            end
            cpuPkg::opAddi: regWrite = 1'b1;
            cpuPkg::opLd: begin
                regWrite = 1'b1;
                memRead  = 1'b1;
            end
            cpuPkg::opSt:   memWrite = 1'b1;
            cpuPkg::opHalt: halt = 1'b1;
            default: ;
        endcase
    end

    // Writeback port
    assign wbWrite = memWb.valid && memWb.regWrite;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_CNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wbWrite) begin
            regs[memWb.rd] <= memWb.data;
        end
    end

    // Same-cycle write bypass
    assign rsVal = (wbWrite && memWb.rd == rs) ? memWb.data : regs[rs];
    assign rtVal = (wbWrite && memWb.rd == rt) ? memWb.data : regs[rt];

    assign idExNext.valid    = ifId.valid;
    assign idExNext.op       = op;
    assign idExNext.rd       = rdF;
    assign idExNext.rs       = rs;
    assign idExNext.rt       = rtF;
    assign idExNext.rsVal    = rsVal;
    assign idExNext.rtVal    = rtVal;
    assign idExNext.imm      = imm;
    assign idExNext.pcPlus1  = ifId.pcPlus1;
    assign idExNext.regWrite = regWrite;
    assign idExNext.memRead  = memRead;
    assign idExNext.memWrite = memWrite;
    assign idExNext.halt     = halt;

endmodule

`default_nettype wire

/* hazardUnit.sv */
////////////////////////////////////////////////////////////
// Forwarding, stall and flush control
////////////////////////////////////////////////////////////

`default_nettype none

module hazardUnit (
    input  cpuPkg::idExT   idEx,
    input  cpuPkg::exMemT  exMem,
    input  cpuPkg::memWbT  memWb,
    input  cpuPkg::regIdxT rs,
    input  cpuPkg::regIdxT rt,
    input  wire            usesRt,
    input  wire            branchTaken,
    input  wire            memBusy,
    output logic           stallFront,
    output logic           bubbleIdEx,
    output logic           flushFront,
    output logic           stallAll,
    output logic [1:0]     fwdA,
    output logic [1:0]     fwdB,
    output logic [1:0]     fwdStore
);

    logic loadUse;

    // 1 takes EX/MEM, 2 takes MEM/WB, 0 keeps the register value
    function automatic logic [1:0] fwdSel(input cpuPkg::regIdxT src,
                                          input cpuPkg::exMemT  older1,
                                          input cpuPkg::memWbT  older2);
        if (older1.valid && older1.regWrite && !older1.memRead && older1.rd == src) begin
            return 2'd1;
        end else if (older2.valid && older2.regWrite && older2.rd == src) begin
            return 2'd2;
        end
        return 2'd0;
    endfunction

    assign fwdA     = fwdSel(idEx.rs, exMem, memWb);
    assign fwdB     = fwdSel(idEx.rt, exMem, memWb);
    assign fwdStore = fwdSel(idEx.rd, exMem, memWb);

    // Load result is not ready until it reaches MEM/WB
    assign loadUse = idEx.valid && idEx.memRead &&
                     (idEx.rd == rs || (usesRt && idEx.rd == rt));

    assign stallAll   = memBusy;
    assign stallFront = memBusy || loadUse;
    assign flushFront = branchTaken && !memBusy;
    assign bubbleIdEx = (loadUse || branchTaken) && !memBusy;

endmodule

`default_nettype wire

/* executeStage.sv */
////////////////////////////////////////////////////////////
// Execute, ALU and branch resolution
////////////////////////////////////////////////////////////

`default_nettype none

`include "cpu_defines.svh"

module executeStage (
    input  cpuPkg::idExT       idEx,
    input  wire  [1:0]         fwdA,
    input  wire  [1:0]         fwdB,
    input  wire  [1:0]         fwdStore,
    input  wire  [`WORD_W-1:0] exMemResult,
    input  wire  [`WORD_W-1:0] memWbData,
    output cpuPkg::exMemT      exMemNext,
    output logic               branchTaken,
    output logic [`WORD_W-1:0] target,
    output logic               err
);

    cpuPkg::wordT opA;
    cpuPkg::wordT opB;
    cpuPkg::wordT storeData;
    cpuPkg::wordT result;
    logic         illegal;
    logic         condMet;

    function automatic cpuPkg::wordT pickOperand(input logic [1:0]   sel,
                                                 input cpuPkg::wordT regVal,
                                                 input cpuPkg::wordT exMemVal,
                                                 input cpuPkg::wordT memWbVal);
        case (sel)
            2'd1:    return exMemVal;
            2'd2:    return memWbVal;
            default: return regVal;
        endcase
    endfunction

    assign opA       = pickOperand(fwdA, idEx.rsVal, exMemResult, memWbData);
    assign opB       = pickOperand(fwdB, idEx.rtVal, exMemResult, memWbData);
    assign storeData = pickOperand(fwdStore, idEx.rtVal, exMemResult, memWbData);

    always_comb begin
        result  = '0;
        condMet = 1'b0;
        illegal = 1'b0;
        case (idEx.op)
            cpuPkg::opNop, cpuPkg::opHalt: ;
            cpuPkg::opAdd: result = opA + opB;
            cpuPkg::opSub: result = opA - opB;
            cpuPkg::opAnd: result = opA & opB;
            cpuPkg::opXor: result = opA ^ opB;
            // Address or immediate sum
            cpuPkg::opAddi, cpuPkg::opLd, cpuPkg::opSt: result = opA + idEx.imm;
            cpuPkg::opBeqz: condMet = (opA == '0);
            cpuPkg::opBnez: condMet = (opA != '0);
            default: illegal = 1'b1;
        endcase
    end

    assign branchTaken = idEx.valid && condMet;
    assign target      = idEx.pcPlus1 + idEx.imm;
    assign err         = idEx.valid && illegal;

    // An illegal word leaves EX as a bubble
    assign exMemNext.valid     = idEx.valid && !illegal;
    assign exMemNext.result    = result;
    assign exMemNext.storeData = storeData;
    assign exMemNext.rd        = idEx.rd;
    assign exMemNext.regWrite  = idEx.regWrite;
    assign exMemNext.memRead   = idEx.memRead;
    assign exMemNext.memWrite  = idEx.memWrite;
    assign exMemNext.halt      = idEx.halt;

endmodule

`default_nettype wire

/* memStage.sv */
////////////////////////////////////////////////////////////
// Memory stage, Wishbone master
////////////////////////////////////////////////////////////

`default_nettype none

`include "cpu_defines.svh"

module memStage (
    input  wire                clk,
    input  wire                rstN,
    input  cpuPkg::exMemT      exMem,
    input  wire                errIn,
    output cpuPkg::memWbT      memWbNext,
    output logic               memBusy,
    output logic               halted,
    output logic               err,
    output logic               wbCyc,
    output logic               wbStb,
    output logic               wbWe,
    output logic [`WORD_W-1:0] wbAdr,
    output logic [`WORD_W-1:0] wbWrData,
    input  wire  [`WORD_W-1:0] wbRdData,
    input  wire                wbAck
);

    logic memReq;
    logic ackSeen;
    logic done;
    logic stopped;
    logic haltQ;
    logic errQ;

    assign stopped = haltQ || errQ;
    assign memReq  = exMem.valid && (exMem.memRead || exMem.memWrite) && !stopped;

    // Idle one cycle after each ack before the next access
    assign wbCyc    = memReq && !ackSeen;
    assign wbStb    = wbCyc;
    assign wbWe     = wbStb && exMem.memWrite;
    assign wbAdr    = exMem.result;
    assign wbWrData = exMem.storeData;
    assign done     = wbStb && wbAck;

    // Also freezes the whole pipeline once stopped
    assign memBusy = (memReq && !done) || stopped;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            ackSeen <= 1'b0;
            errQ    <= 1'b0;
            haltQ   <= 1'b0;
        end else begin
            ackSeen <= done;
            errQ    <= errQ || (errIn && !memBusy);
            // HALT entering MEM/WB, or err from the cycle before
            haltQ   <= haltQ || errQ || (memWbNext.valid && memWbNext.halt && !memBusy);
        end
    end

    assign halted = haltQ;
    assign err    = errQ;

    // Load data is taken in the ack cycle
    assign memWbNext.valid    = exMem.valid;
    assign memWbNext.data     = exMem.memRead ? wbRdData : exMem.result;
    assign memWbNext.rd       = exMem.rd;
    assign memWbNext.regWrite = exMem.regWrite;
    assign memWbNext.halt     = exMem.halt;

endmodule

`default_nettype wire

/* cpuTop.sv */
////////////////////////////////////////////////////////////
// Five-stage CPU top level
////////////////////////////////////////////////////////////

`default_nettype none

`include "cpu_defines.svh"

module cpuTop (
    input  wire                clk,
    input  wire                rstN,
    output logic [`WORD_W-1:0] instrAddr,
    input  wire  [`WORD_W-1:0] instrData,
    output logic               wbCyc,
    output logic               wbStb,
    output logic               wbWe,
    output logic [`WORD_W-1:0] wbAdr,
    output logic [`WORD_W-1:0] wbWrData,
    input  wire  [`WORD_W-1:0] wbRdData,
    input  wire                wbAck,
    output logic               halted,
    output logic               err
);

    cpuPkg::ifIdT   ifIdNext;
    cpuPkg::ifIdT   ifId;
    cpuPkg::idExT   idExNext;
    cpuPkg::idExT   idEx;
    cpuPkg::exMemT  exMemNext;
    cpuPkg::exMemT  exMem;
    cpuPkg::memWbT  memWbNext;
    cpuPkg::memWbT  memWb;

    cpuPkg::regIdxT decRs;
    cpuPkg::regIdxT decRt;
    logic           usesRt;
    logic           stallFront;
    logic           bubbleIdEx;
    logic           flushFront;
    logic           stallAll;
    logic [1:0]     fwdA;
    logic [1:0]     fwdB;
    logic [1:0]     fwdStore;
    logic           branchTaken;
    logic [`WORD_W-1:0] target;
    logic           exErr;
    logic           memBusy;

    fetchStage fetch0 (
        .clk(clk), .rstN(rstN), .stall(stallFront), .redirect(branchTaken),
        .target(target), .halted(halted), .instrData(instrData),
        .instrAddr(instrAddr), .ifIdNext(ifIdNext)
    );

    pipeReg #(.payloadT(cpuPkg::ifIdT)) ifIdReg0 (
        .clk(clk), .rstN(rstN), .stall(stallFront), .flush(flushFront),
        .d(ifIdNext), .q(ifId)
    );

    // Writeback is the MEM/WB payload fed straight into the register file
    decodeStage decode0 (
        .clk(clk), .rstN(rstN), .ifId(ifId), .memWb(memWb),
        .idExNext(idExNext), .rs(decRs), .rt(decRt), .usesRt(usesRt)
    );

    pipeReg #(.payloadT(cpuPkg::idExT)) idExReg0 (
        .clk(clk), .rstN(rstN), .stall(stallAll), .flush(bubbleIdEx),
        .d(idExNext), .q(idEx)
    );

    executeStage exec0 (
        .idEx(idEx), .fwdA(fwdA), .fwdB(fwdB), .fwdStore(fwdStore),
        .exMemResult(exMem.result), .memWbData(memWb.data),
        .exMemNext(exMemNext), .branchTaken(branchTaken), .target(target), .err(exErr)
    );

    pipeReg #(.payloadT(cpuPkg::exMemT)) exMemReg0 (
        .clk(clk), .rstN(rstN), .stall(stallAll), .flush(1'b0),
        .d(exMemNext), .q(exMem)
    );

    memStage mem0 (
        .clk(clk), .rstN(rstN), .exMem(exMem), .errIn(exErr),
        .memWbNext(memWbNext), .memBusy(memBusy), .halted(halted), .err(err),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
        .wbWrData(wbWrData), .wbRdData(wbRdData), .wbAck(wbAck)
    );

    pipeReg #(.payloadT(cpuPkg::memWbT)) memWbReg0 (
        .clk(clk), .rstN(rstN), .stall(stallAll), .flush(1'b0),
        .d(memWbNext), .q(memWb)
    );

    hazardUnit hazard0 (
        .idEx(idEx), .exMem(exMem), .memWb(memWb),
        .rs(decRs), .rt(decRt), .usesRt(usesRt),
        .branchTaken(branchTaken), .memBusy(memBusy),
        .stallFront(stallFront), .bubbleIdEx(bubbleIdEx), .flushFront(flushFront),
        .stallAll(stallAll), .fwdA(fwdA), .fwdB(fwdB), .fwdStore(fwdStore)
    );

endmodule

`default_nettype wire

/* cpuTb.sv */
////////////////////////////////////////////////////////////
// CPU directed testbench
////////////////////////////////////////////////////////////

`default_nettype none

`include "cpu_defines.svh"

module cpuTb;

    logic               clk = 1'b0;
    logic               rstN = 1'b0;
    logic [`WORD_W-1:0] instrAddr;
    logic [`WORD_W-1:0] instrData;
    logic               wbCyc;
    logic               wbStb;
    logic               wbWe;
    logic [`WORD_W-1:0] wbAdr;
    logic [`WORD_W-1:0] wbWrData;
    logic [`WORD_W-1:0] wbRdData = '0;
    logic               wbAck = 1'b0;
    logic               halted;
    logic               err;

    // Program ROM, slave memory and the image it restarts from
    logic [`WORD_W-1:0] rom [64];
    logic [`WORD_W-1:0] dataMem [256];
    logic [`WORD_W-1:0] initMem [256];
    logic [`WORD_W-1:0] refMem [256];
    // Entries are {address, data}
    logic [31:0]        storeLog [$];
    logic [31:0]        refLog [$];
    integer             seed = 32'h1152f87d;
    logic               randomWaits = 1'b0;
    logic               waitArmed = 1'b0;
    int                 waitLeft = 0;
    int                 waitNow;

    always #10 clk = ~clk;

    cpuTop dut0 (
        .clk(clk), .rstN(rstN), .instrAddr(instrAddr), .instrData(instrData),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
        .wbWrData(wbWrData), .wbRdData(wbRdData), .wbAck(wbAck),
        .halted(halted), .err(err)
    );

    assign instrData = rom[instrAddr[5:0]];

    // Wishbone classic slave with registered ack after zero to three waits
    always @(posedge clk) begin
        if (!rstN) begin
            wbAck     <= 1'b0;
            waitArmed <= 1'b0;
            storeLog.delete();
            for (int a = 0; a < 256; a++) begin
                dataMem[a] <= initMem[a];
            end
        end else if (wbAck) begin
            wbAck     <= 1'b0;
            waitArmed <= 1'b0;
        end else if (wbCyc && wbStb) begin
            waitNow = waitArmed ? waitLeft :
                      (randomWaits ? int'($unsigned($random(seed)) % 4) : 0);
            if (waitNow == 0) begin
                wbAck    <= 1'b1;
                wbRdData <= dataMem[wbAdr[7:0]];
                if (wbWe) begin
                    dataMem[wbAdr[7:0]] <= wbWrData;
                    storeLog.push_back({wbAdr, wbWrData});
                end
            end else begin
                waitArmed <= 1'b1;
                waitLeft  <= waitNow - 1;
            end
        end
    end

    function automatic logic [15:0] encodeReg(input logic [3:0] op, input int rd,
                                              input int rs, input int rt);
        return {op, 3'(rd), 3'(rs), 3'(rt), 3'b000};
    endfunction

    function automatic logic [15:0] encodeImm(input logic [3:0] op, input int rd,
                                              input int rs, input int imm);
        return {op, 3'(rd), 3'(rs), 6'(imm)};
    endfunction

    task automatic reportMismatch(input string name, input string what,
                                  input logic [31:0] exp, input logic [31:0] act);
        $display("ERR %s %s: expected %h, actual %h", name, what, exp, act);
        $display("Errors found");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic reportProblem(input string name, input string what);
        $display("%s: %s", name, what);
        $display("Errors found");
        $fatal(1, "stopped at first problem");
    endtask

    // HALT words in every ROM slot and memory words tagged with their address
    task automatic clearImage();
        for (int a = 0; a < 64; a++) begin
            rom[a] = {4'hA, 6'd0, 6'(a)};
        end
        for (int a = 0; a < 256; a++) begin
            initMem[a] = {8'hB0, 8'(a)};
        end
    endtask

    task automatic applyReset();
        @(posedge clk);
        rstN <= 1'b0;
        repeat (8) @(posedge clk);
        rstN <= 1'b1;
    endtask

    // Instruction-level model of the ISA over the same ROM and image
    task automatic runReference(output logic refErr);
        logic [15:0] regs [`REG_CNT];
        logic [15:0] pc;
        logic [15:0] ins;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] imm;
        logic [15:0] addr;
        logic        stop;
        refErr = 1'b0;
        stop   = 1'b0;
        pc     = 16'(`RESET_PC);
        refLog.delete();
        for (int r = 0; r < `REG_CNT; r++) begin
            regs[r] = '0;
        end
        for (int m = 0; m < 256; m++) begin
            refMem[m] = initMem[m];
        end
        for (int step = 0; step < 1000 && !stop; step++) begin
            ins  = rom[pc[5:0]];
            a    = regs[ins[8:6]];
            b    = regs[ins[5:3]];
            imm  = {{10{ins[5]}}, ins[5:0]};
            addr = a + imm;
            pc   = pc + 16'd1;
            case (ins[15:12])
                cpuPkg::opNop: ;
                cpuPkg::opAdd:  regs[ins[11:9]] = a + b;
                cpuPkg::opSub:  regs[ins[11:9]] = a - b;
                cpuPkg::opAnd:  regs[ins[11:9]] = a & b;
                cpuPkg::opXor:  regs[ins[11:9]] = a ^ b;
                cpuPkg::opAddi: regs[ins[11:9]] = addr;
                cpuPkg::opLd:   regs[ins[11:9]] = refMem[addr[7:0]];
                cpuPkg::opSt: begin
                    refMem[addr[7:0]] = regs[ins[11:9]];
                    refLog.push_back({addr, regs[ins[11:9]]});
                end
                cpuPkg::opBeqz: pc = (a == '0) ? pc + imm : pc;
                cpuPkg::opBnez: pc = (a != '0) ? pc + imm : pc;
                cpuPkg::opHalt: stop = 1'b1;
                default: begin
                    refErr = 1'b1;
                    stop   = 1'b1;
                end
            endcase
        end
    endtask

    task automatic runAndCheck(input string name, input logic withWaits);
        int   cycles;
        logic refErr;
        randomWaits = withWaits;
        applyReset();
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > 3000) begin
                reportProblem(name, "timed out waiting for halted");
            end
        end while (!halted);
        // Machine must stay quiet once halted
        repeat (4) begin
            @(negedge clk);
            assert (!wbCyc && !wbStb) else reportProblem(name, "bus cycle started after halt");
        end
        runReference(refErr);
        assert (err == refErr) else reportMismatch(name, "err", 32'(refErr), 32'(err));
        assert (storeLog.size() == refLog.size())
            else reportMismatch(name, "store count", refLog.size(), storeLog.size());
        foreach (refLog[i]) begin
            assert (storeLog[i] == refLog[i])
                else reportMismatch(name, "store", refLog[i], storeLog[i]);
        end
        for (int m = 0; m < 256; m++) begin
            assert (dataMem[m] == refMem[m])
                else reportMismatch(name, "memory word", 32'(refMem[m]), 32'(dataMem[m]));
        end
    endtask

    task automatic resetStateTest();
        applyReset();
        @(negedge clk);
        assert (!wbCyc && !wbStb && !wbWe)
            else reportProblem("resetState", "bus active after reset");
        assert (!halted && !err) else reportProblem("resetState", "halted or err set in reset");
        assert (instrAddr == `WORD_W'(`RESET_PC))
            else reportMismatch("resetState", "instrAddr", 32'(`RESET_PC), 32'(instrAddr));
    endtask

    // Back-to-back dependencies through both forwarding paths
    task automatic loadAluProgram();
        clearImage();
        rom[0]  = encodeImm(cpuPkg::opAddi, 1, 0, 7);
        rom[1]  = encodeImm(cpuPkg::opAddi, 2, 1, -3);
        rom[2]  = encodeReg(cpuPkg::opAdd, 3, 1, 2);
        rom[3]  = encodeReg(cpuPkg::opSub, 4, 3, 1);
        rom[4]  = encodeReg(cpuPkg::opAnd, 5, 4, 3);
        rom[5]  = encodeReg(cpuPkg::opXor, 6, 5, 2);
        rom[6]  = encodeImm(cpuPkg::opSt, 3, 0, 16);
        rom[7]  = encodeImm(cpuPkg::opSt, 4, 0, 17);
        rom[8]  = encodeImm(cpuPkg::opSt, 6, 0, 18);
        rom[9]  = encodeImm(cpuPkg::opAddi, 7, 6, 31);
        rom[10] = encodeImm(cpuPkg::opSt, 7, 0, 19);
        rom[11] = encodeReg(cpuPkg::opXor, 1, 7, 3);
        rom[12] = encodeImm(cpuPkg::opSt, 1, 0, 20);
    endtask

    task automatic aluChainTest();
        loadAluProgram();
        runAndCheck("aluChain", 1'b0);
    endtask

    task automatic loadUseTest();
        clearImage();
        initMem[20] = 16'h1234;
        initMem[21] = 16'h0F0F;
        rom[0] = encodeImm(cpuPkg::opLd, 1, 0, 20);
        rom[1] = encodeReg(cpuPkg::opAdd, 2, 1, 1);
        rom[2] = encodeImm(cpuPkg::opLd, 3, 0, 21);
        rom[3] = encodeReg(cpuPkg::opAdd, 4, 3, 1);
        rom[4] = encodeImm(cpuPkg::opSt, 4, 0, 22);
        rom[5] = encodeImm(cpuPkg::opSt, 2, 0, 23);
        rom[6] = encodeImm(cpuPkg::opLd, 5, 0, 22);
        rom[7] = encodeImm(cpuPkg::opSt, 5, 0, 24);
        runAndCheck("loadUse", 1'b0);
    endtask

    // Counted loop, then taken and untaken BEQZ and BNEZ
    task automatic branchTest();
        int loopStores;
        clearImage();
        rom[0]  = encodeImm(cpuPkg::opAddi, 1, 0, 3);
        rom[1]  = encodeImm(cpuPkg::opAddi, 2, 0, 0);
        rom[2]  = encodeImm(cpuPkg::opSt, 1, 2, 8);
        rom[3]  = encodeImm(cpuPkg::opAddi, 2, 2, 1);
        rom[4]  = encodeImm(cpuPkg::opAddi, 1, 1, -1);
        rom[5]  = encodeImm(cpuPkg::opBnez, 0, 1, -4);
        rom[6]  = encodeImm(cpuPkg::opBeqz, 0, 1, 2);
        rom[7]  = encodeImm(cpuPkg::opSt, 1, 0, 25);
        rom[8]  = encodeImm(cpuPkg::opSt, 1, 0, 26);
        rom[9]  = encodeImm(cpuPkg::opBnez, 0, 1, 3);
        rom[10] = encodeImm(cpuPkg::opSt, 2, 0, 12);
        rom[11] = encodeImm(cpuPkg::opAddi, 3, 0, 5);
        rom[12] = encodeImm(cpuPkg::opBeqz, 0, 3, 2);
        rom[13] = encodeImm(cpuPkg::opSt, 3, 0, 13);
        rom[14] = encodeImm(cpuPkg::opBnez, 0, 3, 2);
        rom[15] = encodeImm(cpuPkg::opSt, 3, 0, 27);
        rom[16] = encodeImm(cpuPkg::opSt, 3, 0, 28);
        runAndCheck("branches", 1'b0);
        loopStores = 0;
        foreach (storeLog[i]) begin
            if (storeLog[i][31:16] >= 16'd8 && storeLog[i][31:16] < 16'd11) begin
                loopStores++;
            end
        end
        assert (loopStores == 3) else reportMismatch("branches", "loop stores", 3, loopStores);
    endtask

    task automatic backPressureTest();
        loadAluProgram();
        runAndCheck("backPressure", 1'b1);
    endtask

    task automatic illegalOpcodeTest();
        clearImage();
        rom[0] = encodeImm(cpuPkg::opAddi, 1, 0, 9);
        rom[1] = encodeImm(cpuPkg::opSt, 1, 0, 10);
        rom[2] = 16'hF123;
        rom[3] = encodeImm(cpuPkg::opSt, 1, 0, 11);
        rom[4] = encodeImm(cpuPkg::opAddi, 2, 0, 1);
        rom[5] = encodeImm(cpuPkg::opSt, 2, 0, 12);
        runAndCheck("illegalOpcode", 1'b0);
        assert (err) else reportProblem("illegalOpcode", "err did not rise");
    endtask

    initial begin
        clearImage();
        resetStateTest();
        aluChainTest();
        loadUseTest();
        branchTest();
        backPressureTest();
        illegalOpcodeTest();
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+.
cpuPkg.sv
pipeReg.sv
fetchStage.sv
decodeStage.sv
hazardUnit.sv
executeStage.sv
memStage.sv
cpuTop.sv
cpuTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the CPU testbench with Verilator and run it
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module cpuTb -Mdir obj_dir -f flist.f
buildStatus=$?
if [ "$buildStatus" -ne 0 ]; then
    echo "Verilator build failed with status $buildStatus"
    exit 1
fi

./obj_dir/VcpuTb
simStatus=$?
if [ "$simStatus" -ne 0 ]; then
    echo "Simulation failed with status $simStatus"
    exit "$simStatus"
fi

echo "Simulation finished cleanly"
exit 0
